// ==== ibi_target.f ====
+incdir+verilog
verilog/i3c_bus_pkg.sv
verilog/ibi_pkg.sv
verilog/bus_req_if.sv
verilog/bus_monitor.sv
verilog/bus_tx.sv
verilog/bus_rx.sv
verilog/ibi_queue.sv
verilog/ibi.sv
verilog/ibi_target.sv
verif/ibi_target_tb.sv

// ==== Bender.yml ====
package:
  name: ibi_target

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/i3c_bus_pkg.sv
      - verilog/ibi_pkg.sv
      - verilog/bus_req_if.sv
      - verilog/bus_monitor.sv
      - verilog/bus_tx.sv
      - verilog/bus_rx.sv
      - verilog/ibi_queue.sv
      - verilog/ibi.sv
      - verilog/ibi_target.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/ibi_target_tb.sv

// ==== verif/ibi_target_tb.sv ====
// Controller model clocks SCL at 32 clk_i per period; rows share DUT state and run in order
`timescale 1ns/1ps
`include "ibi_config.svh"

module ibi_target_tb import ibi_pkg::*; ();

  localparam int HalfPeriod = 16;
  localparam int Timeout    = 5000;
  localparam int NumRows    = 11;

  // One IBI attempt and what the bus and status should show
  typedef struct {
    logic [6:0]  addr;
    logic        addr_valid;
    int          n_bytes;
    logic        ack;
    int          stop_idx;
    logic [2:0]  retry;
    ibi_status_e status;
    logic        on_bus;
  } row_t;

  logic        clk_i;
  logic        rst_ni;
  logic        scl_drv;
  logic        sda_drv;
  logic        sda_line;
  logic        sda_o;
  logic        sda_pp_en_o;
  logic        wr_valid;
  logic [7:0]  wr_data;
  logic        wr_last;
  logic        wr_ready;
  logic [6:0]  addr;
  logic        addr_valid;
  logic [2:0]  retry_num;
  logic        begin_ibi;
  logic        done;
  ibi_status_e status;
  logic        status_we;

  row_t        rows [NumRows];
  logic [7:0]  exp_q [$];
  logic [31:0] lfsr;
  int          errors = 0;
  int          timeouts = 0;
  int          done_cnt = 0;
  int          we_cnt = 0;
  int          start_cnt = 0;
  ibi_status_e last_status = IbiSuccess;
  logic        prev_scl = 1'b1;
  logic        prev_sda = 1'b1;

  // Open-drain bus, either side pulls low
  assign sda_line = sda_drv & sda_o;

  ibi_target dut0 (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .scl_i                   (scl_drv),
    .sda_i                   (sda_line),
    .sda_o                   (sda_o),
    .sda_pp_en_o             (sda_pp_en_o),
    .ibi_wr_valid_i          (wr_valid),
    .ibi_wr_data_i           (wr_data),
    .ibi_wr_last_i           (wr_last),
    .ibi_wr_ready_o          (wr_ready),
    .target_ibi_addr_i       (addr),
    .target_ibi_addr_valid_i (addr_valid),
    .ibi_retry_num_i         (retry_num),
    .begin_i                 (begin_ibi),
    .done_o                  (done),
    .ibi_status_o            (status),
    .ibi_status_we_o         (status_we)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Pulse counters, sampled away from the active edge
  always @(negedge clk_i) begin
    if (done) begin
      done_cnt    = done_cnt + 1;
      last_status = status;
    end
    if (status_we) begin
      we_cnt = we_cnt + 1;
    end
    // START from the DUT is SDA falling while SCL stays high
    if (prev_scl && scl_drv && prev_sda && !sda_line) begin
      start_cnt = start_cnt + 1;
    end
    prev_scl = scl_drv;
    prev_sda = sda_line;
  end

  task automatic check_status(input string name, input ibi_status_e exp,
                              input ibi_status_e act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [6:0] exp, input logic [6:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per payload bit
  task automatic next_payload_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic step_clk(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // SCL low on entry and on exit, SDA sampled at the end of SCL high
  task automatic clock_bit(input logic drive, output logic sample);
    step_clk(4);
    sda_drv = drive;
    step_clk(HalfPeriod - 4);
    scl_drv = 1'b1;
    step_clk(HalfPeriod);
    sample  = sda_line;
    scl_drv = 1'b0;
  endtask

  // SDA low under SCL low, then SDA rises while SCL is high
  task automatic send_stop();
    step_clk(4);
    sda_drv = 1'b0;
    step_clk(HalfPeriod - 4);
    scl_drv = 1'b1;
    step_clk(HalfPeriod / 2);
    sda_drv = 1'b1;
    step_clk(HalfPeriod);
  endtask

  task automatic run_controller(input row_t r, input string name);
    logic [7:0] hdr;
    logic [7:0] got;
    logic       bit_v;
    logic       t_bit;
    int         n;
    int         wait_cnt;
    bit         stopped;

    wait_cnt = 0;
    while (sda_line && wait_cnt < Timeout) begin
      step_clk(1);
      wait_cnt++;
    end
    if (sda_line) begin
      timeouts++;
      $display("Timeout: %s saw no START from the DUT", name);
      return;
    end
    step_clk(HalfPeriod);
    scl_drv = 1'b0;

    hdr = '0;
    for (int i = 0; i < 8; i++) begin
      clock_bit(1'b1, bit_v);
      hdr = {hdr[6:0], bit_v};
    end
    check_addr({name, " address"}, r.addr, hdr[7:1]);
    check_flag({name, " rnw"}, 1'b0, hdr[0]);
    // Address goes out open-drain
    check_flag({name, " address push-pull"}, 1'b0, sda_pp_en_o);
    // Ninth bit, low for ACK
    clock_bit(!r.ack, bit_v);
    if (!r.ack) begin
      send_stop();
      return;
    end

    n       = exp_q.size();
    stopped = 0;
    got     = '0;
    for (int i = 0; i < n && !stopped; i++) begin
      for (int j = 0; j < 8; j++) begin
        clock_bit(1'b1, bit_v);
        got = {got[6:0], bit_v};
      end
      check_byte($sformatf("%s byte %0d", name, i), exp_q.pop_front(), got);
      // Payload goes out push-pull
      check_flag($sformatf("%s byte %0d push-pull", name, i), 1'b1, sda_pp_en_o);
      if (i == r.stop_idx) begin
        // STOP over the T bit, which the DUT holds high here
        send_stop();
        stopped = 1;
      end else begin
        clock_bit(1'b1, t_bit);
        check_flag($sformatf("%s T bit %0d", name, i), (i != n - 1), t_bit);
        if (!t_bit) begin
          send_stop();
          stopped = 1;
        end
      end
    end
    if (!stopped) begin
      send_stop();
    end
  endtask

  task automatic write_bytes(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      next_payload_byte(b);
      wr_valid = 1'b1;
      wr_data  = b;
      wr_last  = (i == n - 1);
      exp_q.push_back(b);
      step_clk(1);
    end
    wr_valid = 1'b0;
    wr_last  = 1'b0;
  endtask

  task automatic wait_done(input int base, input string name);
    int wait_cnt;
    wait_cnt = 0;
    while (done_cnt == base && wait_cnt < Timeout) begin
      step_clk(1);
      wait_cnt++;
    end
    if (done_cnt == base) begin
      timeouts++;
      $display("Timeout: %s never pulsed done", name);
    end
  endtask

  task automatic apply_row(input int idx);
    row_t  r;
    string name;
    int    done_base;
    int    we_base;
    int    start_base;
    int    wait_cnt;

    r    = rows[idx];
    name = $sformatf("row %0d", idx);
    write_bytes(r.n_bytes);
    step_clk(1);
    check_flag({name, " wr_ready before begin"}, exp_q.size() < `IBI_QUEUE_DEPTH, wr_ready);
    done_base  = done_cnt;
    we_base    = we_cnt;
    start_base = start_cnt;
    addr       = r.addr;
    addr_valid = r.addr_valid;
    retry_num  = r.retry;
    begin_ibi  = 1'b1;
    step_clk(1);
    begin_ibi  = 1'b0;

    if (!r.addr_valid) begin
      // Whole window must stay quiet
      wait_cnt = 0;
      while (done_cnt == done_base && start_cnt == start_base && wait_cnt < Timeout) begin
        step_clk(1);
        wait_cnt++;
      end
      check_count({name, " done pulses"}, 0, done_cnt - done_base);
      check_count({name, " STARTs"}, 0, start_cnt - start_base);
      return;
    end

    if (r.on_bus) begin
      run_controller(r, name);
    end
    wait_done(done_base, name);
    step_clk(4);
    check_count({name, " done pulses"}, 1, done_cnt - done_base);
    check_count({name, " status_we pulses"}, 1, we_cnt - we_base);
    check_count({name, " STARTs"}, r.on_bus ? 1 : 0, start_cnt - start_base);
    check_status({name, " status"}, r.status, last_status);
    // Flushed bytes never reach the bus
    if (!r.on_bus || r.stop_idx >= 0) begin
      exp_q.delete();
    end
    check_flag({name, " wr_ready after done"}, exp_q.size() < `IBI_QUEUE_DEPTH, wr_ready);
    step_clk(HalfPeriod);
  endtask

  task automatic load_table();
    rows[0]  = '{7'h2a, 1'b1, 3, 1'b1, -1, 3'd7, IbiSuccess,            1'b1};
    rows[1]  = '{7'h55, 1'b1, 2, 1'b0, -1, 3'd1, IbiFailureNack,        1'b1};
    rows[2]  = '{7'h55, 1'b1, 0, 1'b0, -1, 3'd1, IbiFailureRetry,       1'b1};
    // Fills the queue, retries are used up so it is flushed
    rows[3]  = '{7'h55, 1'b1, 6, 1'b0, -1, 3'd1, IbiFailureRetry,       1'b0};
    rows[4]  = '{7'h13, 1'b1, 2, 1'b1, -1, 3'd7, IbiSuccess,            1'b1};
    rows[5]  = '{7'h13, 1'b1, 4, 1'b1,  1, 3'd7, IbiFailurePartialData, 1'b1};
    rows[6]  = '{7'h7f, 1'b0, 0, 1'b1, -1, 3'd7, IbiSuccess,            1'b0};
    // Two NACKs leave the retry count at 1
    rows[7]  = '{7'h44, 1'b1, 0, 1'b0, -1, 3'd7, IbiFailureRetry,       1'b1};
    rows[8]  = '{7'h44, 1'b1, 0, 1'b0, -1, 3'd7, IbiFailureRetry,       1'b1};
    rows[9]  = '{7'h44, 1'b1, 2, 1'b1, -1, 3'd7, IbiSuccess,            1'b1};
    // Would be flushed if the count had not returned to 7
    rows[10] = '{7'h44, 1'b1, 0, 1'b0, -1, 3'd1, IbiFailureNack,        1'b1};
  endtask

  initial begin
    rst_ni     = 1'b0;
    scl_drv    = 1'b1;
    sda_drv    = 1'b1;
    wr_valid   = 1'b0;
    wr_data    = '0;
    wr_last    = 1'b0;
    addr       = '0;
    addr_valid = 1'b0;
    retry_num  = 3'd7;
    begin_ibi  = 1'b0;
    lfsr       = 32'h6dfa_b611;
    load_table();

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    step_clk(2);
    check_flag("reset sda_o", 1'b1, sda_o);
    check_flag("reset sda_pp_en_o", 1'b0, sda_pp_en_o);
    check_flag("reset done_o", 1'b0, done);
    check_flag("reset status_we", 1'b0, status_we);
    check_status("reset status", IbiSuccess, status);

    for (int i = 0; i < NumRows; i++) begin
      apply_row(i);
    end

    $display("Summary: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verilog/ibi_target.sv ====
// SDA is open-drain unless sda_pp_en_o is high; sda_i must be the resolved bus line
`timescale 1ns/1ps

module ibi_target import ibi_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        sda_o,
  output logic        sda_pp_en_o,
  input  logic        ibi_wr_valid_i,
  input  logic [7:0]  ibi_wr_data_i,
  input  logic        ibi_wr_last_i,
  output logic        ibi_wr_ready_o,
  input  logic [6:0]  target_ibi_addr_i,
  input  logic        target_ibi_addr_valid_i,
  input  logic [2:0]  ibi_retry_num_i,
  input  logic        begin_i,
  output logic        done_o,
  output ibi_status_e ibi_status_o,
  output logic        ibi_status_we_o
);

  ibi_byte_t wr_entry, rd_entry;
  logic      rd_valid, rd_ready;
  logic      scl_negedge, scl_posedge, bus_stop, bus_avail, sda_sync;
  logic      sda_start, sda_tx;

  bus_req_if bus_if ();

  always_comb begin
    wr_entry.data = ibi_wr_data_i;
    wr_entry.last = ibi_wr_last_i;
  end

  ibi_queue u_queue (
    .clk_i, .rst_ni,
    .wr_valid_i (ibi_wr_valid_i),
    .wr_data_i  (wr_entry),
    .wr_ready_o (ibi_wr_ready_o),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_entry),
    .rd_ready_i (rd_ready)
  );

  bus_monitor u_monitor (
    .clk_i, .rst_ni, .scl_i, .sda_i,
    .scl_negedge_o (scl_negedge),
    .scl_posedge_o (scl_posedge),
    .stop_o        (bus_stop),
    .bus_avail_o   (bus_avail),
    .sda_sync_o    (sda_sync)
  );

  bus_tx u_tx (
    .clk_i, .rst_ni,
    .scl_negedge_i (scl_negedge),
    .scl_posedge_i (scl_posedge),
    .bus           (bus_if.shifter),
    .sda_o         (sda_tx),
    .sda_pp_o      (sda_pp_en_o)
  );

  bus_rx u_rx (
    .clk_i, .rst_ni,
    .scl_posedge_i (scl_posedge),
    .sda_i         (sda_sync),
    .bus           (bus_if.shifter)
  );

  ibi u_ibi (
    .clk_i, .rst_ni, .ibi_retry_num_i, .begin_i, .done_o,
    .ibi_status_o, .ibi_status_we_o,
    .target_ibi_addr_i, .target_ibi_addr_valid_i,
    .ibi_byte_valid_i (rd_valid),
    .ibi_byte_i       (rd_entry),
    .ibi_byte_ready_o (rd_ready),
    .scl_negedge_i    (scl_negedge),
    .bus_available_i  (bus_avail),
    .bus_stop_i       (bus_stop),
    .bus              (bus_if.fsm),
    .sda_start_o      (sda_start)
  );

  // Either source may pull SDA low
  assign sda_o = sda_start & sda_tx;

endmodule

// ==== verilog/ibi.sv ====
// Ignores begin_i without a valid address; retry number 7 means retry without limit
`timescale 1ns/1ps

module ibi import ibi_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [2:0]  ibi_retry_num_i,
  input  logic        begin_i,
  output logic        done_o,
  output ibi_status_e ibi_status_o,
  output logic        ibi_status_we_o,
  input  logic [6:0]  target_ibi_addr_i,
  input  logic        target_ibi_addr_valid_i,
  input  logic        ibi_byte_valid_i,
  input  ibi_byte_t   ibi_byte_i,
  output logic        ibi_byte_ready_o,
  input  logic        scl_negedge_i,
  input  logic        bus_available_i,
  input  logic        bus_stop_i,
  bus_req_if.fsm      bus,
  output logic        sda_start_o
);

  ibi_state_e  state_q;
  ibi_status_e status_q;
  logic [2:0]  retry_cnt_q;
  logic        nacked_q;
  logic        can_retry;
  logic        nack;

  // Sampled SDA high on the ACK bit
  assign nack = bus.rx_value[0];

  assign can_retry = (ibi_retry_num_i == 3'd7) || (ibi_retry_num_i != retry_cnt_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      case (state_q)
        Idle: begin
          if (begin_i && target_ibi_addr_valid_i) begin
            state_q <= can_retry ? WaitAvail : Flush;
          end
        end
        WaitAvail: begin
          if (bus_stop_i) state_q <= Done;
          else if (bus_available_i) state_q <= DriveStart;
        end
        DriveStart: begin
          if (bus_stop_i) state_q <= Done;
          else if (scl_negedge_i) state_q <= DriveAddr;
        end
        DriveAddr: begin
          if (bus_stop_i) state_q <= Done;
          else if (bus.tx_done) state_q <= ReadAck;
        end
        ReadAck: begin
          if (bus_stop_i) state_q <= Done;
          else if (bus.rx_done) state_q <= nack ? WaitStop : SendData;
        end
        SendData: begin
          if (bus_stop_i) state_q <= Flush;
          else if (bus.tx_done) state_q <= SendTbit;
        end
        SendTbit: begin
          if (bus_stop_i) state_q <= Flush;
          else if (bus.tx_done) state_q <= ibi_byte_i.last ? Done : SendData;
        end
        WaitStop: begin
          if (bus_stop_i) state_q <= Done;
        end
        // Drain what is left of this IBI
        Flush: begin
          if (!ibi_byte_valid_i) state_q <= Done;
        end
        Done:    state_q <= Idle;
        default: state_q <= Idle;
      endcase
    end
  end

  assign sda_start_o = (state_q != DriveStart);

  // Shifter requests per state
  always_comb begin
    bus.tx_req_byte = 1'b0;
    bus.tx_req_bit  = 1'b0;
    bus.tx_value    = '0;
    bus.tx_pp       = 1'b0;
    bus.rx_req_byte = 1'b0;
    bus.rx_req_bit  = 1'b0;
    case (state_q)
      DriveAddr: begin
        bus.tx_req_byte       = 1'b1;
        bus.tx_value.hdr.addr = target_ibi_addr_i;
        bus.tx_value.hdr.rnw  = 1'b0;
      end
      ReadAck: bus.rx_req_bit = 1'b1;
      SendData: begin
        bus.tx_req_byte   = 1'b1;
        bus.tx_value.data = ibi_byte_i.data;
        bus.tx_pp         = 1'b1;
      end
      // T bit of 0 ends the IBI
      SendTbit: begin
        bus.tx_req_bit    = 1'b1;
        bus.tx_value.data = {7'd0, !ibi_byte_i.last};
        bus.tx_pp         = 1'b1;
      end
      default: ;
    endcase
  end

  assign ibi_byte_ready_o = (state_q == Flush) || (state_q == SendTbit && bus.tx_done);

  // First failure keeps its code, repeated failures report retry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= IbiSuccess;
    end else begin
      case (state_q)
        SendData, SendTbit: begin
          if (bus_stop_i) begin
            status_q <= (status_q == IbiSuccess) ? IbiFailurePartialData : IbiFailureRetry;
          end else if (state_q == SendTbit && bus.tx_done && ibi_byte_i.last) begin
            status_q <= IbiSuccess;
          end
        end
        ReadAck: begin
          if (bus.rx_done && nack) begin
            status_q <= (status_q == IbiSuccess) ? IbiFailureNack : IbiFailureRetry;
          end
        end
        default: ;
      endcase
    end
  end

  // NACK seen during the current attempt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nacked_q <= 1'b0;
    end else if (state_q == Idle) begin
      nacked_q <= 1'b0;
    end else if (state_q == ReadAck && bus.rx_done && nack) begin
      nacked_q <= 1'b1;
    end
  end

  // 7 wraps to 0 on the first NACK
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retry_cnt_q <= 3'd7;
    end else if (state_q == Done) begin
      retry_cnt_q <= nacked_q ? retry_cnt_q + 1'b1 : 3'd7;
    end
  end

  assign done_o          = (state_q == Done);
  assign ibi_status_we_o = (state_q == Done);
  assign ibi_status_o    = status_q;

endmodule

// ==== verilog/ibi_queue.sv ====
// Writes are dropped while full; a write and a pop may share a cycle
`timescale 1ns/1ps
`include "ibi_config.svh"

module ibi_queue import ibi_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wr_valid_i,
  input  ibi_byte_t wr_data_i,
  output logic      wr_ready_o,
  output logic      rd_valid_o,
  output ibi_byte_t rd_data_o,
  input  logic      rd_ready_i
);

  localparam int Depth = `IBI_QUEUE_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  ibi_byte_t       mem [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push, pop;

  assign wr_ready_o = (count_q != CntW'(Depth));
  assign rd_valid_o = (count_q != '0);
  assign push       = wr_valid_i & wr_ready_o;
  assign pop        = rd_valid_o & rd_ready_i;
  assign rd_data_o  = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // Pointers wrap for any depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== verilog/bus_rx.sv ====
// Samples on SCL rising edges only; a bit request takes priority over a byte request
`timescale 1ns/1ps

module bus_rx import i3c_bus_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_posedge_i,
  input  logic sda_i,
  bus_req_if.shifter bus
);

  logic     busy_q, done_q;
  logic [2:0] cnt_q;
  rx_word_t value_q;
  logic     req, start;

  assign req   = bus.rx_req_byte | bus.rx_req_bit;
  assign start = !busy_q && !done_q && req && scl_posedge_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (busy_q && !req) begin
        busy_q <= 1'b0;
      end else if (start) begin
        if (bus.rx_req_bit) begin
          done_q <= 1'b1;
        end else begin
          busy_q <= 1'b1;
          cnt_q  <= 3'd6;
        end
      end else if (busy_q && scl_posedge_i) begin
        if (cnt_q == 3'd0) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // Newest sample lands in bit 0
  always_ff @(posedge clk_i) begin
    if (start || (busy_q && scl_posedge_i)) begin
      value_q <= {value_q[6:0], sda_i};
    end
  end

  assign bus.rx_done  = done_q;
  assign bus.rx_value = value_q;

endmodule

// ==== verilog/bus_tx.sv ====
// Starts at once if SCL is already low, else on the next falling edge; holds SDA until then
`timescale 1ns/1ps

module bus_tx (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_negedge_i,
  input  logic scl_posedge_i,
  bus_req_if.shifter bus,
  output logic sda_o,
  output logic sda_pp_o
);

  logic       busy_q, done_q, scl_low_q;
  logic [7:0] shift_q;
  logic [2:0] cnt_q;
  logic       req, start;

  assign req   = bus.tx_req_byte | bus.tx_req_bit;
  assign start = !busy_q && !done_q && req && (scl_negedge_i || scl_low_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      scl_low_q <= 1'b0;
      cnt_q     <= '0;
      sda_o     <= 1'b1;
      sda_pp_o  <= 1'b0;
    end else begin
      done_q <= 1'b0;

      // SCL level rebuilt from the strobes
      if (scl_negedge_i) begin
        scl_low_q <= 1'b1;
      end else if (scl_posedge_i) begin
        scl_low_q <= 1'b0;
      end

      if (busy_q && !req) begin
        // Request withdrawn, e.g. after a STOP
        busy_q   <= 1'b0;
        sda_o    <= 1'b1;
        sda_pp_o <= 1'b0;
      end else if (start) begin
        busy_q   <= 1'b1;
        sda_pp_o <= bus.tx_pp;
        if (bus.tx_req_byte) begin
          cnt_q <= 3'd7;
          sda_o <= bus.tx_value.data[7];
        end else begin
          cnt_q <= 3'd0;
          sda_o <= bus.tx_value.data[0];
        end
      end else if (busy_q) begin
        if (scl_posedge_i && cnt_q == 3'd0) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else if (scl_negedge_i) begin
          cnt_q <= cnt_q - 1'b1;
          sda_o <= shift_q[7];
        end
      end else if (scl_negedge_i) begin
        // Last bit held through SCL high, released here
        sda_o    <= 1'b1;
        sda_pp_o <= 1'b0;
      end
    end
  end

  // Remaining bits, MSB next
  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= {bus.tx_value.data[6:0], 1'b1};
    end else if (busy_q && scl_negedge_i) begin
      shift_q <= {shift_q[6:0], 1'b1};
    end
  end

  assign bus.tx_done = done_q;

endmodule

// ==== verilog/bus_monitor.sv ====
// Strobes lag the pins by sync stages plus one cycle; needs at least 2 sync stages
`timescale 1ns/1ps
`include "ibi_config.svh"

module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_negedge_o,
  output logic scl_posedge_o,
  output logic stop_o,
  output logic bus_avail_o,
  output logic sda_sync_o
);

  localparam int SyncStages  = `IBI_SYNC_STAGES;
  localparam int AvailCycles = `IBI_BUS_AVAIL_CYCLES;
  localparam int CntW        = $clog2(AvailCycles + 1);

  logic [SyncStages-1:0] scl_sync_q, sda_sync_q;
  logic                  scl_prev_q, sda_prev_q;
  logic                  scl_s, sda_s;
  logic                  sda_fall, stop_det;
  logic                  armed_q;
  logic [CntW-1:0]       idle_cnt_q;

  assign scl_s    = scl_sync_q[SyncStages-1];
  assign sda_s    = sda_sync_q[SyncStages-1];
  assign sda_fall = sda_prev_q & ~sda_s;
  assign stop_det = ~sda_prev_q & sda_s & scl_s;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q    <= '1;
      sda_sync_q    <= '1;
      scl_prev_q    <= 1'b1;
      sda_prev_q    <= 1'b1;
      scl_negedge_o <= 1'b0;
      scl_posedge_o <= 1'b0;
      stop_o        <= 1'b0;
    end else begin
      scl_sync_q    <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q    <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q    <= scl_s;
      sda_prev_q    <= sda_s;
      scl_negedge_o <= scl_prev_q & ~scl_s;
      scl_posedge_o <= ~scl_prev_q & scl_s;
      stop_o        <= stop_det;
    end
  end

  // Bus free detection, armed by reset or STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q     <= 1'b1;
      idle_cnt_q  <= '0;
      bus_avail_o <= 1'b0;
    end else if (sda_fall) begin
      armed_q     <= 1'b0;
      idle_cnt_q  <= '0;
      bus_avail_o <= 1'b0;
    end else if (stop_det) begin
      armed_q    <= 1'b1;
      idle_cnt_q <= '0;
    end else if (armed_q && !bus_avail_o) begin
      if (scl_s && sda_s) begin
        if (idle_cnt_q == CntW'(AvailCycles - 1)) begin
          bus_avail_o <= 1'b1;
        end else begin
          idle_cnt_q <= idle_cnt_q + 1'b1;
        end
      end else begin
        idle_cnt_q <= '0;
      end
    end
  end

  assign sda_sync_o = sda_s;

endmodule

// ==== verilog/bus_req_if.sv ====
// Requests are levels held per FSM state; done strobes last one clk_i cycle
`timescale 1ns/1ps

interface bus_req_if import i3c_bus_pkg::*; ();

  // Transmit side
  logic     tx_req_byte;
  logic     tx_req_bit;
  tx_word_u tx_value;
  logic     tx_pp;
  logic     tx_done;

  // Receive side
  logic     rx_req_byte;
  logic     rx_req_bit;
  logic     rx_done;
  rx_word_t rx_value;

  modport fsm (
    output tx_req_byte, tx_req_bit, tx_value, tx_pp,
    input  tx_done,
    output rx_req_byte, rx_req_bit,
    input  rx_done, rx_value
  );

  modport shifter (
    input  tx_req_byte, tx_req_bit, tx_value, tx_pp,
    output tx_done,
    input  rx_req_byte, rx_req_bit,
    output rx_done, rx_value
  );

endinterface

// ==== verilog/ibi_pkg.sv ====
// IBI-level types; status encodings match the TTI LAST_IBI_STATUS field
package ibi_pkg;

  typedef enum logic [1:0] {
    IbiSuccess            = 2'b00,
    IbiFailureNack        = 2'b01,
    IbiFailurePartialData = 2'b10,
    IbiFailureRetry       = 2'b11
  } ibi_status_e;

  typedef enum logic [3:0] {
    Idle,
    WaitAvail,
    DriveStart,
    DriveAddr,
    ReadAck,
    SendData,
    SendTbit,
    WaitStop,
    Flush,
    Done
  } ibi_state_e;

  // Queue entry, last marks the final byte of one IBI
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } ibi_byte_t;

endpackage

// ==== verilog/i3c_bus_pkg.sv ====
// Bus-level word types; MSB goes out first on SDA and rx bit 0 is the latest sample
package i3c_bus_pkg;

  // Address header as sent after START
  typedef struct packed {
    logic [6:0] addr;
    logic       rnw;
  } tx_hdr_t;

  // One transmit word, read either as header or as plain data
  typedef union packed {
    tx_hdr_t    hdr;
    logic [7:0] data;
  } tx_word_u;

  // Received word, for a single-bit read 1 in bit 0 means NACK
  typedef logic [7:0] rx_word_t;

endpackage

// ==== verilog/ibi_config.svh ====
// Build-time sizing; SCL must run far slower than clk_i and sync stages must be at least 2
`ifndef IBI_CONFIG_SVH
`define IBI_CONFIG_SVH

// Entries in the IBI byte queue
`define IBI_QUEUE_DEPTH 8

// Idle cycles with both lines high before the bus counts as free
`define IBI_BUS_AVAIL_CYCLES 16

// Synchronizer flops on SCL and SDA
`define IBI_SYNC_STAGES 2

`endif
